// File: flist.f
+incdir+hw
hw/exec_pkg.sv
hw/regfile.sv
hw/alu.sv
hw/rep_counter.sv
hw/exec_fsm.sv
hw/apb_regs.sv
hw/exec_top.sv
verification/tb_exec.sv

// File: hw/alu.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module alu (
  input  exec_pkg::opcode_t op,
  input  logic              word,
  input  exec_pkg::word_t   x,
  input  exec_pkg::word_t   y,
  input  exec_pkg::flags_t  fin,
  output exec_pkg::word_t   res,
  output exec_pkg::word_t   hi,
  output exec_pkg::flags_t  fout
);
  import exec_pkg::*;

  localparam int CF_BIT = 0;
  localparam int PF_BIT = 2;
  localparam int AF_BIT = 4;
  localparam int ZF_BIT = 6;
  localparam int SF_BIT = 7;
  localparam int OF_BIT = 11;

  logic        sub_op;
  logic [16:0] sum_w;
  logic [8:0]  sum_b;
  logic [31:0] prod_w;
  logic [15:0] prod_b;
  logic        xm;
  logic        ym;
  word_t       r;
  logic        rm;
  logic        cf;
  logic        af;
  logic        of;

  // CMP is a SUB whose result is thrown away
  assign sub_op = (op == `OP_SUB) || (op == `OP_CMP);

  assign sum_w = sub_op ? ({1'b0, x} - {1'b0, y}) : ({1'b0, x} + {1'b0, y});
  assign sum_b = sub_op ? ({1'b0, x[7:0]} - {1'b0, y[7:0]})
                        : ({1'b0, x[7:0]} + {1'b0, y[7:0]});

  assign prod_w = {16'h0000, x} * {16'h0000, y};
  assign prod_b = {8'h00, x[7:0]} * {8'h00, y[7:0]};

  assign xm = word ? x[15] : x[7];
  assign ym = word ? y[15] : y[7];

  always_comb begin
    r  = y;
    hi = 16'h0000;
    cf = 1'b0;
    af = 1'b0;
    of = 1'b0;
    rm = 1'b0;
    case (op)
      `OP_ADD, `OP_SUB, `OP_CMP: begin
        r  = word ? sum_w[15:0] : {{8{sum_b[7]}}, sum_b[7:0]};
        cf = word ? sum_w[16] : sum_b[8];
        af = x[4] ^ y[4] ^ r[4];
      end
      `OP_AND: r = x & y;
      `OP_OR:  r = x | y;
      `OP_XOR: r = x ^ y;
      `OP_MUL: begin
        if (word) begin
          r  = prod_w[15:0];
          hi = prod_w[31:16];
        end else begin
          r  = prod_b;
          hi = {8'h00, prod_b[15:8]};
        end
        cf = (hi != 16'h0000);
      end
      default: r = y;
    endcase

    rm = word ? r[15] : r[7];
    if (op == `OP_MUL) begin
      of = cf;
    end else if (op == `OP_ADD) begin
      of = (xm == ym) && (rm != xm);
    end else if (sub_op) begin
      // Signed overflow on subtract needs operands of opposite sign
      of = (xm != ym) && (rm != xm);
    end

    fout = fin;
    if (op != `OP_MOV) begin
      fout[CF_BIT] = cf;
      fout[PF_BIT] = ~^r[7:0];
      fout[AF_BIT] = af;
      fout[ZF_BIT] = word ? (r == 16'h0000) : (r[7:0] == 8'h00);
      fout[SF_BIT] = rm;
      fout[OF_BIT] = of;
    end
    res = r;
  end

endmodule

// File: hw/apb_regs.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module apb_regs (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`APB_ADDR_W-1:0] paddr,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`APB_DATA_W-1:0] pwdata,
  output logic [`APB_DATA_W-1:0] prdata,
  output logic                   pready,
  output logic                   pslverr,
  input  logic                   busy,
  input  logic                   skipped,
  output logic                   cmd_valid,
  output exec_pkg::opcode_t      cmd_op,
  output exec_pkg::reg_addr_t    cmd_dst,
  output exec_pkg::reg_addr_t    cmd_src,
  output logic                   cmd_word,
  output logic                   cmd_rep,
  output logic                   host_wr,
  output exec_pkg::reg_addr_t    host_addr,
  output exec_pkg::word_t        host_data,
  output exec_pkg::reg_addr_t    addr_c,
  output exec_pkg::seg_sel_t     addr_s,
  input  exec_pkg::word_t        c,
  input  exec_pkg::word_t        s,
  input  exec_pkg::word_t        cs,
  input  exec_pkg::flags_t       oflags
);

  logic wr_access;
  logic hit_cmd;
  logic hit_reg;
  logic hit_seg;

  assign wr_access = psel && penable && pwrite;
  assign hit_cmd   = (paddr == `CMD_ADDR);
  assign hit_reg   = ((paddr & `REG_MASK) == `REG_BASE);
  assign hit_seg   = ((paddr & `SEG_MASK) == `SEG_BASE);

  // Zero wait states, a busy slice refuses commands and loads
  assign pready    = 1'b1;
  assign pslverr   = wr_access && busy && (hit_cmd || hit_reg);
  assign cmd_valid = wr_access && hit_cmd && !busy;
  assign host_wr   = wr_access && hit_reg && !busy;

  assign host_addr = paddr[5:2];
  assign host_data = pwdata[15:0];
  assign addr_c    = paddr[5:2];
  assign addr_s    = paddr[3:2];

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_op   <= `OP_MOV;
      cmd_dst  <= 4'd0;
      cmd_src  <= 4'd0;
      cmd_word <= 1'b0;
      cmd_rep  <= 1'b0;
    end else if (cmd_valid) begin
      cmd_op   <= pwdata[`CMD_OP];
      cmd_dst  <= pwdata[`CMD_DST];
      cmd_src  <= pwdata[`CMD_SRC];
      cmd_word <= pwdata[`CMD_WORD];
      cmd_rep  <= pwdata[`CMD_REP];
    end
  end

  always_comb begin
    prdata = '0;
    if (hit_reg) begin
      prdata[15:0] = c;
    end else if (hit_seg) begin
      prdata[15:0] = s;
    end else if (paddr == `FLAGS_ADDR) begin
      prdata[15:0] = oflags;
    end else if (paddr == `CS_ADDR) begin
      prdata[15:0] = cs;
    end else if (paddr == `STATUS_ADDR) begin
      prdata[`STS_BUSY] = busy;
      prdata[`STS_SKIP] = skipped;
    end else if (hit_cmd) begin
      // Last accepted command reads back in its own layout
      prdata[`CMD_OP]   = cmd_op;
      prdata[`CMD_DST]  = cmd_dst;
      prdata[`CMD_SRC]  = cmd_src;
      prdata[`CMD_WORD] = cmd_word;
      prdata[`CMD_REP]  = cmd_rep;
    end
  end

endmodule

// File: hw/exec_defs.svh
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// APB bus widths
`define APB_ADDR_W   8
`define APB_DATA_W   32

// APB register map, byte offsets
`define CMD_ADDR     8'h00
`define STATUS_ADDR  8'h04
`define FLAGS_ADDR   8'h08
`define CS_ADDR      8'h0C
`define SEG_BASE     8'h20
`define SEG_MASK     8'hF0
`define REG_BASE     8'h40
`define REG_MASK     8'hC0

// Operation codes carried in CMD bits 2:0
`define OP_MOV       3'd0
`define OP_ADD       3'd1
`define OP_SUB       3'd2
`define OP_AND       3'd3
`define OP_OR        3'd4
`define OP_XOR       3'd5
`define OP_CMP       3'd6
`define OP_MUL       3'd7

// CMD word fields
`define CMD_OP       2:0
`define CMD_DST      7:4
`define CMD_SRC      11:8
`define CMD_WORD     12
`define CMD_REP      13

// STATUS bits
`define STS_BUSY     0
`define STS_SKIP     1

`define CX_IDX       4'd1

`endif

// File: hw/exec_fsm.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_fsm (
  input  logic                clk,
  input  logic                rst,
  input  logic                cmd_valid,
  input  exec_pkg::opcode_t   cmd_op,
  input  exec_pkg::reg_addr_t cmd_dst,
  input  exec_pkg::reg_addr_t cmd_src,
  input  logic                cmd_word,
  input  logic                cmd_rep,
  input  logic                host_wr,
  input  exec_pkg::reg_addr_t host_addr,
  input  exec_pkg::word_t     host_data,
  output logic                busy,
  output logic                skipped,
  output exec_pkg::reg_addr_t addr_a,
  output exec_pkg::reg_addr_t addr_b,
  output logic                o_byte,
  output exec_pkg::reg_addr_t addr_d,
  output exec_pkg::wide_t     d,
  output logic                wr,
  output logic                wrfl,
  output logic                wrhi,
  output logic                word_op,
  output exec_pkg::flags_t    iflags,
  input  exec_pkg::word_t     alu_res,
  input  exec_pkg::word_t     alu_hi,
  input  exec_pkg::flags_t    alu_flags,
  input  logic                cx_zero,
  input  exec_pkg::word_t     cx_value,
  output logic                rep_load,
  output exec_pkg::word_t     rep_value,
  output logic                rep_dec,
  input  exec_pkg::word_t     rep_count,
  input  logic                rep_expired
);
  import exec_pkg::*;

  exec_state_t state;
  exec_state_t state_nx;
  logic        skip_q;

  always_comb begin
    state_nx = state;
    case (state)
      IDLE:  if (cmd_valid) state_nx = CHECK;
      CHECK: state_nx = (cmd_rep && cx_zero) ? DONE : EXEC;
      EXEC: begin
        if (!cmd_rep) begin
          state_nx = DONE;
        end else if (rep_expired) begin
          state_nx = CX_WB;
        end
      end
      CX_WB: state_nx = DONE;
      DONE:  state_nx = IDLE;
      default: state_nx = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= IDLE;
      skip_q <= 1'b0;
    end else begin
      state <= state_nx;
      if (state == CHECK) begin
        skip_q <= cmd_rep && cx_zero;
      end
    end
  end

  assign busy    = (state != IDLE);
  assign skipped = skip_q;
  assign iflags  = alu_flags;

  // The count is taken from CX, read on port b while in CHECK
  assign rep_load  = (state == CHECK) && cmd_rep;
  assign rep_value = cx_value;
  assign rep_dec   = (state == EXEC) && cmd_rep;

  // Write port belongs to the host while idle and to the datapath otherwise
  always_comb begin
    addr_a  = cmd_dst;
    addr_b  = cmd_src;
    o_byte  = !cmd_word;
    addr_d  = cmd_dst;
    d       = {alu_hi, alu_res};
    wr      = 1'b0;
    wrfl    = 1'b0;
    wrhi    = 1'b0;
    word_op = cmd_word;
    case (state)
      IDLE: begin
        addr_d  = host_addr;
        d       = {16'h0000, host_data};
        wr      = host_wr;
        word_op = 1'b1;
      end
      CHECK: begin
        addr_b = `CX_IDX;
        o_byte = 1'b0;
      end
      EXEC: begin
        wr   = (cmd_op != `OP_CMP);
        wrfl = (cmd_op != `OP_MOV);
        wrhi = (cmd_op == `OP_MUL) && cmd_word;
      end
      CX_WB: begin
        addr_d  = `CX_IDX;
        d       = {16'h0000, rep_count};
        wr      = 1'b1;
        word_op = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

// File: hw/exec_pkg.sv
package exec_pkg;

  // Register value, operand or result
  typedef logic [15:0] word_t;

  // Register file write data, product high half in bits 31:16
  typedef logic [31:0] wide_t;

  // Register or byte-lane index
  typedef logic [3:0] reg_addr_t;

  // Segment register index (ES, CS, SS, DS)
  typedef logic [1:0] seg_sel_t;

  typedef logic [2:0] opcode_t;

  // 8086 layout: CF 0, PF 2, AF 4, ZF 6, SF 7, TF 8, IF 9, DF 10, OF 11
  typedef logic [15:0] flags_t;

  typedef enum logic [2:0] {
    IDLE,
    CHECK,
    EXEC,
    CX_WB,
    DONE
  } exec_state_t;

endpackage

// File: hw/exec_top.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`APB_ADDR_W-1:0] paddr,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`APB_DATA_W-1:0] pwdata,
  output logic [`APB_DATA_W-1:0] prdata,
  output logic                   pready,
  output logic                   pslverr
);
  import exec_pkg::*;

  word_t     rf_a;
  word_t     rf_b;
  word_t     rf_c;
  word_t     rf_s;
  word_t     rf_cs;
  flags_t    rf_flags;
  flags_t    new_flags;
  flags_t    alu_flags;
  reg_addr_t addr_a;
  reg_addr_t addr_b;
  reg_addr_t addr_c;
  reg_addr_t addr_d;
  seg_sel_t  addr_s;
  wide_t     rf_d;
  logic      wr;
  logic      wrfl;
  logic      wrhi;
  logic      word_op;
  logic      o_byte;
  logic      cx_zero;

  word_t     alu_res;
  word_t     alu_hi;

  logic      busy;
  logic      skipped;
  logic      cmd_valid;
  opcode_t   cmd_op;
  reg_addr_t cmd_dst;
  reg_addr_t cmd_src;
  logic      cmd_word;
  logic      cmd_rep;
  logic      host_wr;
  reg_addr_t host_addr;
  word_t     host_data;

  logic      rep_load;
  logic      rep_dec;
  logic      rep_expired;
  word_t     rep_value;
  word_t     rep_count;

  regfile u_regfile (
    .clk     (clk),
    .rst     (rst),
    .a       (rf_a),
    .b       (rf_b),
    .c       (rf_c),
    .cs      (rf_cs),
    .s       (rf_s),
    .oflags  (rf_flags),
    .cx_zero (cx_zero),
    .addr_a  (addr_a),
    .addr_b  (addr_b),
    .addr_c  (addr_c),
    .addr_d  (addr_d),
    .addr_s  (addr_s),
    .iflags  (new_flags),
    .d       (rf_d),
    .wr      (wr),
    .wrfl    (wrfl),
    .wrhi    (wrhi),
    .word_op (word_op),
    .o_byte  (o_byte),
    .c_byte  (1'b0)
  );

  alu u_alu (
    .op   (cmd_op),
    .word (cmd_word),
    .x    (rf_a),
    .y    (rf_b),
    .fin  (rf_flags),
    .res  (alu_res),
    .hi   (alu_hi),
    .fout (alu_flags)
  );

  rep_counter u_rep_counter (
    .clk        (clk),
    .rst        (rst),
    .load       (rep_load),
    .dec        (rep_dec),
    .load_value (rep_value),
    .count      (rep_count),
    .expired    (rep_expired)
  );

  exec_fsm u_exec_fsm (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid   (cmd_valid),
    .cmd_op      (cmd_op),
    .cmd_dst     (cmd_dst),
    .cmd_src     (cmd_src),
    .cmd_word    (cmd_word),
    .cmd_rep     (cmd_rep),
    .host_wr     (host_wr),
    .host_addr   (host_addr),
    .host_data   (host_data),
    .busy        (busy),
    .skipped     (skipped),
    .addr_a      (addr_a),
    .addr_b      (addr_b),
    .o_byte      (o_byte),
    .addr_d      (addr_d),
    .d           (rf_d),
    .wr          (wr),
    .wrfl        (wrfl),
    .wrhi        (wrhi),
    .word_op     (word_op),
    .iflags      (new_flags),
    .alu_res     (alu_res),
    .alu_hi      (alu_hi),
    .alu_flags   (alu_flags),
    .cx_zero     (cx_zero),
    .cx_value    (rf_b),
    .rep_load    (rep_load),
    .rep_value   (rep_value),
    .rep_dec     (rep_dec),
    .rep_count   (rep_count),
    .rep_expired (rep_expired)
  );

  apb_regs u_apb_regs (
    .clk       (clk),
    .rst       (rst),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .busy      (busy),
    .skipped   (skipped),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_dst   (cmd_dst),
    .cmd_src   (cmd_src),
    .cmd_word  (cmd_word),
    .cmd_rep   (cmd_rep),
    .host_wr   (host_wr),
    .host_addr (host_addr),
    .host_data (host_data),
    .addr_c    (addr_c),
    .addr_s    (addr_s),
    .c         (rf_c),
    .s         (rf_s),
    .cs        (rf_cs),
    .oflags    (rf_flags)
  );

endmodule

// File: hw/regfile.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module regfile (
  input  logic                clk,
  input  logic                rst,
  output exec_pkg::word_t     a,
  output exec_pkg::word_t     b,
  output exec_pkg::word_t     c,
  output exec_pkg::word_t     cs,
  output exec_pkg::word_t     s,
  output exec_pkg::flags_t    oflags,
  output logic                cx_zero,
  input  exec_pkg::reg_addr_t addr_a,
  input  exec_pkg::reg_addr_t addr_b,
  input  exec_pkg::reg_addr_t addr_c,
  input  exec_pkg::reg_addr_t addr_d,
  input  exec_pkg::seg_sel_t  addr_s,
  input  exec_pkg::flags_t    iflags,
  input  exec_pkg::wide_t     d,
  input  logic                wr,
  input  logic                wrfl,
  input  logic                wrhi,
  input  logic                word_op,
  input  logic                o_byte,
  input  logic                c_byte
);
  import exec_pkg::*;

  localparam reg_addr_t DX_IDX = 4'd2;
  localparam reg_addr_t CS_IDX = 4'd9;
  localparam reg_addr_t IP_IDX = 4'd15;

  word_t      r [16];
  // Stored as OF DF IF TF SF ZF AF PF CF
  logic [8:0] fl;
  word_t      cx_next;

  // Indices 4 to 7 in byte mode select the high byte of AX, CX, DX, BX
  function automatic word_t read_port(input reg_addr_t idx, input logic byte_rd);
    logic [7:0] lane;
    if (idx[2]) begin
      lane = r[{2'b00, idx[1:0]}][15:8];
    end else begin
      lane = r[idx][7:0];
    end
    if (byte_rd && !idx[3]) begin
      return {{8{lane[7]}}, lane};
    end
    return r[idx];
  endfunction

  always_comb begin
    a = read_port(addr_a, o_byte);
    b = read_port(addr_b, o_byte);
    c = read_port(addr_c, c_byte);
  end

  assign s  = r[{2'b10, addr_s}];
  assign cs = r[CS_IDX];

  assign oflags = {4'd0, fl[8:3], 1'b0, fl[2], 1'b0, fl[1], 1'b1, fl[0]};

  // CX as it will be after this edge, so a repeat sees a load made in the same cycle
  always_comb begin
    cx_next = r[`CX_IDX];
    if (wr && addr_d == `CX_IDX) begin
      if (word_op) begin
        cx_next = d[15:0];
      end else begin
        cx_next[7:0] = d[7:0];
      end
    end
    if (wr && !word_op && addr_d == (`CX_IDX + 4'd4)) begin
      cx_next[15:8] = d[7:0];
    end
  end

  assign cx_zero = (cx_next == 16'h0000);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        r[i] <= 16'h0000;
      end
      r[CS_IDX] <= 16'hF000;
      r[IP_IDX] <= 16'hFFF0;
      fl        <= 9'd0;
    end else begin
      if (wr) begin
        if (word_op) begin
          r[addr_d] <= d[15:0];
        end else if (addr_d[3:2] == 2'b10) begin
          // Segment registers take the byte sign-extended to a full word
          r[addr_d] <= {{8{d[7]}}, d[7:0]};
        end else if (addr_d[3:2] == 2'b01) begin
          r[{2'b00, addr_d[1:0]}][15:8] <= d[7:0];
        end else begin
          r[addr_d][7:0] <= d[7:0];
        end
      end
      if (wrfl) begin
        fl <= {iflags[11:6], iflags[4], iflags[2], iflags[0]};
      end
      if (wrhi) begin
        r[DX_IDX] <= d[31:16];
      end
    end
  end

endmodule

// File: hw/rep_counter.sv
`timescale 1ns/1ps

module rep_counter (
  input  logic            clk,
  input  logic            rst,
  input  logic            load,
  input  logic            dec,
  input  exec_pkg::word_t load_value,
  output exec_pkg::word_t count,
  output logic            expired
);

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= 16'h0000;
    end else if (load) begin
      count <= load_value;
    end else if (dec && count != 16'h0000) begin
      count <= count - 16'd1;
    end
  end

  // High while the current iteration is the last one
  assign expired = (count == 16'd1);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot change to the project root"
  exit 1
fi

verilator --binary --timing --timescale 1ns/1ps -j 0 -f flist.f \
  --top-module tb_exec --Mdir obj_dir -o sim_exec
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_exec)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" <<< "$out"; then
  exit 0
fi
exit 1

// File: verification/exec_vectors.txt
# L reg value | C cmd pslverr reg value flags | I cmd (no wait) | T cmd reg value flags
# R reg value | S status | E ends a case; all fields hex
L 2 009C
L 0 1234
L 1 5A00
L 3 5678
C 0240 0 0 9C34 0002
C 0530 0 3 565A 0002
C 0280 0 8 FF9C 0002
R 2 009C
E
L 0 7FFF
L 3 0001
C 1301 0 0 8000 0896
E
L 0 0003
L 3 0005
C 1302 0 0 FFFE 0093
E
L 0 8000
L 3 8000
C 1301 0 0 0000 0847
L 6 F0F0
L 7 0FF0
C 1763 0 6 00F0 0006
C 1764 0 6 0FF0 0006
C 1765 0 6 0000 0046
E
L 5 0010
L 4 0020
C 1456 0 5 0010 0087
R 4 0020
E
L 0 1234
L 3 0100
L 2 FFFF
C 1307 0 0 3400 0807
R 2 0012
E
L 0 0010
L 3 0003
L 1 0005
C 3301 0 0 001F 0002
R 1 0000
S 0000
E
L 1 0000
L 0 1111
C 3301 0 0 1111 0002
S 0002
E
L 0 0001
L 3 0002
L 2 5555
I 1301
C 1307 1 2 5555 0006
R 0 0003
E
T 1301 0 0005 0006
E

// File: verification/tb_exec.sv
`timescale 1ns/1ps
`include "exec_defs.svh"

module tb_exec;
  import exec_pkg::*;

  logic        clk;
  logic        rst;
  logic [7:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  string       lines[$];
  int          limit_cycles;
  int          errors;
  int          checks;
  int          cases;
  int          bad_cases;
  int          case_start;
  logic [31:0] seed;

  exec_top uut (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [7:0] reg_window(input reg_addr_t idx);
    return `REG_BASE + {2'b00, idx, 2'b00};
  endfunction

  task automatic check_ready(input logic got, input string what);
    checks++;
    if (got !== 1'b1) begin
      errors++;
      $display("** Error at %0t: %s, pready %b, expected 1", $time, what, got);
    end
  endtask

  // Both bus tasks start and end on a falling edge
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    err = pslverr;
    check_ready(pready, $sformatf("write to %h", addr));
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    data = prdata;
    check_ready(pready, $sformatf("read from %h", addr));
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s, read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flags(input flags_t got, input flags_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s, flags %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s, pslverr %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    int          polls;
    polls = 0;
    apb_read(`STATUS_ADDR, st);
    while (st[`STS_BUSY] && polls < 50) begin
      apb_read(`STATUS_ADDR, st);
      polls++;
    end
    if (st[`STS_BUSY]) begin
      errors++;
      $display("DUT still busy after %0d status polls", polls);
    end
  endtask

  task automatic check_result(input logic [31:0] cmd, input reg_addr_t idx,
                              input word_t value, input flags_t flags);
    logic [31:0] rd;
    apb_read(reg_window(idx), rd);
    check_word(rd[15:0], value, $sformatf("register %0d after command %h", idx, cmd[15:0]));
    apb_read(`FLAGS_ADDR, rd);
    check_flags(rd[15:0], flags, $sformatf("flags after command %h", cmd[15:0]));
  endtask

  task automatic end_case();
    cases++;
    if (errors == case_start) begin
      $display("case %0d ok", cases);
    end else begin
      bad_cases++;
      $display("case %0d had %0d errors", cases, errors - case_start);
    end
    case_start = errors;
  endtask

  task automatic run_line(input string line);
    logic [7:0]  kind;
    string       rest;
    logic [31:0] f0;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;
    logic        err;
    logic [31:0] rd;
    f0 = '0;
    f1 = '0;
    f2 = '0;
    f3 = '0;
    f4 = '0;
    kind = line.getc(0);
    rest = line.substr(1, line.len() - 1);
    void'($sscanf(rest, "%h %h %h %h %h", f0, f1, f2, f3, f4));
    case (kind)
      "L": begin
        apb_write(reg_window(f0[3:0]), {16'h0000, f1[15:0]}, err);
        check_err(err, 1'b0, $sformatf("load of register %0d", f0[3:0]));
      end
      "C": begin
        apb_write(`CMD_ADDR, {16'h0000, f0[15:0]}, err);
        check_err(err, f1[0], $sformatf("command %h", f0[15:0]));
        wait_idle();
        check_result(f0, f2[3:0], f3[15:0], f4[15:0]);
      end
      "I": begin
        apb_write(`CMD_ADDR, {16'h0000, f0[15:0]}, err);
        check_err(err, 1'b0, $sformatf("command %h", f0[15:0]));
      end
      "T": begin
        // Non-repeat command is CHECK, EXEC, DONE, so busy is gone 4 cycles on
        apb_write(`CMD_ADDR, {16'h0000, f0[15:0]}, err);
        check_err(err, 1'b0, $sformatf("command %h", f0[15:0]));
        apb_read(`STATUS_ADDR, rd);
        check_word({15'h0000, rd[`STS_BUSY]}, 16'h0001, "busy 2 cycles after command");
        apb_read(`STATUS_ADDR, rd);
        check_word({15'h0000, rd[`STS_BUSY]}, 16'h0000, "busy 4 cycles after command");
        check_result(f0, f1[3:0], f2[15:0], f3[15:0]);
      end
      "R": begin
        apb_read(reg_window(f0[3:0]), rd);
        check_word(rd[15:0], f1[15:0], $sformatf("register %0d", f0[3:0]));
      end
      "S": begin
        apb_read(`STATUS_ADDR, rd);
        check_word(rd[15:0], f0[15:0], "status");
      end
      "E": end_case();
      default: begin
        errors++;
        $display("Unknown line in vector file: %s", line);
      end
    endcase
  endtask

  initial begin : main
    int          fd;
    string       line;
    word_t       loaded [16];
    word_t       exp;
    logic        err;
    logic [31:0] rd;
    clk          = 1'b0;
    rst          = 1'b1;
    paddr        = 8'h00;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = 32'h0000_0000;
    errors       = 0;
    checks       = 0;
    cases        = 0;
    bad_cases    = 0;
    case_start   = 0;
    limit_cycles = 0;
    seed         = 32'd86271;

    fd = $fopen("verification/exec_vectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open verification/exec_vectors.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0) begin
          if (line.len() > 1 && line.getc(0) != "#") begin
            lines.push_back(line);
          end
        end
      end
      $fclose(fd);
    end
    // Reset and the two built-in cases take about as long as four vector lines
    limit_cycles = (lines.size() + 4) * 40;

    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // CS is register 9 and IP register 15
    for (int i = 0; i < 16; i++) begin
      exp = (i == 9) ? 16'hF000 : (i == 15) ? 16'hFFF0 : 16'h0000;
      apb_read(reg_window(i[3:0]), rd);
      check_word(rd[15:0], exp, $sformatf("register %0d after reset", i));
    end
    apb_read(`CS_ADDR, rd);
    check_word(rd[15:0], 16'hF000, "CS after reset");
    apb_read(`FLAGS_ADDR, rd);
    check_flags(rd[15:0], 16'h0002, "flags after reset");
    apb_read(`STATUS_ADDR, rd);
    check_word(rd[15:0], 16'h0000, "status after reset");
    end_case();

    for (int i = 0; i < 16; i++) begin
      seed = lcg_next(seed);
      loaded[i] = seed[31:16];
      apb_write(reg_window(i[3:0]), {16'h0000, loaded[i]}, err);
      check_err(err, 1'b0, $sformatf("random load of register %0d", i));
    end
    for (int i = 0; i < 16; i++) begin
      apb_read(reg_window(i[3:0]), rd);
      check_word(rd[15:0], loaded[i], $sformatf("readback of register %0d", i));
    end
    for (int j = 0; j < 4; j++) begin
      apb_read(`SEG_BASE + {4'h0, j[1:0], 2'b00}, rd);
      check_word(rd[15:0], loaded[8 + j], $sformatf("segment window %0d", j));
    end
    apb_read(`CS_ADDR, rd);
    check_word(rd[15:0], loaded[9], "CS after load");
    end_case();

    foreach (lines[k]) begin
      run_line(lines[k]);
    end

    $display("cases run %0d, cases with errors %0d, checks %0d, errors %0d",
             cases, bad_cases, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Watchdog expired, the run did not finish within %0d cycles", limit_cycles);
    $display("test failed");
    $finish;
  end

endmodule
